// File: Bender.yml
package:
  name: spike_conv

sources:
  - rtl/spike_conv_pkg.sv
  - rtl/conv_ctrl.sv
  - rtl/weight_buf.sv
  - rtl/ifmap_row_buf.sv
  - rtl/pe_channel.sv
  - rtl/channel_add_tree.sv
  - rtl/psum_accum.sv
  - rtl/lif_fire.sv
  - rtl/spike_conv_top.sv
  - target: simulation
    files:
      - verif/tb_spike_conv.sv

// File: compile.f
rtl/spike_conv_pkg.sv
rtl/conv_ctrl.sv
rtl/weight_buf.sv
rtl/ifmap_row_buf.sv
rtl/pe_channel.sv
rtl/channel_add_tree.sv
rtl/psum_accum.sv
rtl/lif_fire.sv
rtl/spike_conv_top.sv
verif/tb_spike_conv.sv

// File: rtl/channel_add_tree.sv
// registered sum of all channel rows, time-step tag carried along
`timescale 1ns/1ps

module channel_add_tree
    import spike_conv_pkg::*;
(
    input  logic                     s_clk,
    input  logic                     s_rst,
    input  logic                     i_valid,
    input  logic [T_W-1:0]           i_t,
    input  ch_sum_row_t [PE_NUM-1:0] i_sums,
    output logic                     o_valid,
    output logic [T_W-1:0]           o_t,
    output tree_row_t                o_row
);

    tree_row_t w_row;

    always_comb begin
        logic signed [TREE_W-1:0] acc;
        for (int x = 0; x < OUT_W; x++) begin
            acc = '0;
            for (int c = 0; c < PE_NUM; c++) begin
                acc = acc + TREE_W'($signed(i_sums[c][x]));
            end
            w_row[x] = acc;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_valid) begin
            o_row <= w_row;
            o_t   <= i_t;
        end
    end

endmodule

// File: rtl/conv_ctrl.sv
// job controller: state machine, beat, time-step, drain and pass counters
// load ready signals and buffer write strobes
`timescale 1ns/1ps

module conv_ctrl
    import spike_conv_pkg::*;
(
    input  logic              s_clk,
    input  logic              s_rst,
    input  logic              i_cfg_valid,
    input  logic [PASS_W-1:0] i_cfg_passes,
    input  logic              i_weight_valid,
    input  logic              i_spikes_valid,
    input  logic              i_out_taken,
    output logic              o_weight_ready,
    output logic              o_spikes_ready,
    output logic              o_w_we,
    output logic              o_row_we,
    output logic [BEAT_W-1:0] o_beat_idx,
    output logic              o_cal_valid,
    output logic [T_W-1:0]    o_cal_t,
    output logic              o_first_pass,
    output logic              o_fire_start
);

    ctrl_state_e       r_state;
    ctrl_state_e       w_next;
    logic [BEAT_W-1:0] r_beat;
    logic [T_W-1:0]    r_t;
    logic [1:0]        r_drain;
    logic [PASS_W-1:0] r_passes;
    logic [PASS_W-1:0] r_pass_cnt;
    logic              w_w_done;
    logic              w_row_done;
    logic              w_cal_last;
    logic              w_drain_last;
    logic              w_last_pass;

    assign o_weight_ready = (r_state == S_LOAD_W);
    assign o_spikes_ready = (r_state == S_LOAD_ROWS);
    assign o_w_we         = i_weight_valid & o_weight_ready;
    assign o_row_we       = i_spikes_valid & o_spikes_ready;
    assign o_beat_idx     = r_beat;
    assign o_cal_valid    = (r_state == S_CAL);
    assign o_cal_t        = r_t;
    assign o_first_pass   = (r_pass_cnt == '0);
    assign o_fire_start   = (r_state == S_FIRE);

    assign w_w_done     = o_w_we && (r_beat == BEAT_W'(W_BEATS - 1));
    assign w_row_done   = o_row_we && (r_beat == BEAT_W'(ROW_BEATS - 1));
    assign w_cal_last   = o_cal_valid && (r_t == T_W'(TIME_STEPS - 1));
    assign w_drain_last = (r_state == S_DRAIN) && (r_drain == 2'(DRAIN_CYC - 1));
    assign w_last_pass  = (r_pass_cnt == r_passes - 1'b1);

    always_comb begin
        w_next = r_state;
        case (r_state)
            S_IDLE:      w_next = S_LOAD_W;
            S_LOAD_W:    if (w_w_done) w_next = S_LOAD_ROWS;
            S_LOAD_ROWS: if (w_row_done) w_next = S_CAL;
            S_CAL:       if (w_cal_last) w_next = S_DRAIN;
            S_DRAIN:     if (w_drain_last) w_next = w_last_pass ? S_FIRE : S_LOAD_W;
            S_FIRE:      w_next = S_OUT;
            S_OUT:       if (i_out_taken) w_next = S_IDLE;
            default:     w_next = S_IDLE;
        endcase
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_state    <= S_IDLE;
            r_beat     <= '0;
            r_t        <= '0;
            r_drain    <= '0;
            r_passes   <= PASS_W'(1);
            r_pass_cnt <= '0;
        end else begin
            r_state <= w_next;
            if (i_cfg_valid) begin
                r_passes <= i_cfg_passes;
            end
            // one counter serves both load streams
            if (w_w_done || w_row_done) begin
                r_beat <= '0;
            end else if (o_w_we || o_row_we) begin
                r_beat <= r_beat + 1'b1;
            end
            if (w_cal_last) begin
                r_t <= '0;
            end else if (o_cal_valid) begin
                r_t <= r_t + 1'b1;
            end
            if (w_drain_last) begin
                r_drain <= '0;
                // pass count moves only after the last psum write
                r_pass_cnt <= w_last_pass ? '0 : r_pass_cnt + 1'b1;
            end else if (r_state == S_DRAIN) begin
                r_drain <= r_drain + 1'b1;
            end
        end
    end

endmodule

// File: rtl/ifmap_row_buf.sv
// spike row register file, one image row written per beat
`timescale 1ns/1ps

module ifmap_row_buf
    import spike_conv_pkg::*;
(
    input  logic                               s_clk,
    input  logic                               s_rst,
    input  logic                               i_we,
    input  logic [BEAT_W-1:0]                  i_idx,
    input  spike_row_t                         i_spikes,
    output spike_row_t [PE_NUM-1:0][KSIZE-1:0] o_rows
);

    // same layout as the kernels, channel then row
    spike_row_t [ROW_BEATS-1:0] r_mem;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_mem <= '0;
        end else if (i_we) begin
            r_mem[i_idx] <= i_spikes;
        end
    end

    assign o_rows = r_mem;

endmodule

// File: rtl/lif_fire.sv
// integrate-and-fire over time steps with threshold register
// output spike register and valid/ready handshake
`timescale 1ns/1ps

module lif_fire
    import spike_conv_pkg::*;
(
    input  logic                     s_clk,
    input  logic                     s_rst,
    input  logic                     i_cfg_valid,
    input  logic signed [THRD_W-1:0] i_cfg_thrd,
    input  logic                     i_fire_start,
    input  psum_row_t                i_psum,
    input  logic                     i_out_ready,
    output logic                     o_out_valid,
    output out_spikes_t              o_out_spikes,
    output logic                     o_out_taken
);

    logic signed [THRD_W-1:0] r_thrd;
    out_spikes_t              w_spikes;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_thrd <= '0;
        end else if (i_cfg_valid) begin
            r_thrd <= i_cfg_thrd;
        end
    end

    // membrane starts at zero and resets after each spike
    always_comb begin
        logic signed [MEM_W-1:0] mem;
        for (int x = 0; x < OUT_W; x++) begin
            mem = '0;
            for (int t = 0; t < TIME_STEPS; t++) begin
                mem = mem + MEM_W'($signed(i_psum[t][x]));
                if (mem >= MEM_W'(r_thrd)) begin
                    w_spikes[TIME_STEPS*x + t] = 1'b1;
                    mem = '0;
                end else begin
                    w_spikes[TIME_STEPS*x + t] = 1'b0;
                end
            end
        end
    end

    assign o_out_taken = o_out_valid & i_out_ready;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_out_valid <= 1'b0;
        end else if (i_fire_start) begin
            o_out_valid <= 1'b1;
        end else if (o_out_taken) begin
            o_out_valid <= 1'b0;
        end
    end

    // held until the next job fires
    always_ff @(posedge s_clk) begin
        if (i_fire_start) begin
            o_out_spikes <= w_spikes;
        end
    end

endmodule

// File: rtl/pe_channel.sv
// one input channel: 3x3 binary-spike convolution of one output row
// for one time step, registered with its time-step tag
`timescale 1ns/1ps

module pe_channel
    import spike_conv_pkg::*;
(
    input  logic                     s_clk,
    input  logic                     s_rst,
    input  logic                     i_valid,
    input  logic [T_W-1:0]           i_t,
    input  weight_row_t [KSIZE-1:0]  i_kernel,
    input  spike_row_t [KSIZE-1:0]   i_rows,
    output logic                     o_valid,
    output logic [T_W-1:0]           o_t,
    output ch_sum_row_t              o_sums
);

    ch_sum_row_t w_sums;

    // spikes are binary, so each tap only gates its weight
    always_comb begin
        logic signed [CH_SUM_W-1:0] acc;
        for (int x = 0; x < OUT_W; x++) begin
            acc = '0;
            for (int ky = 0; ky < KSIZE; ky++) begin
                for (int kx = 0; kx < KSIZE; kx++) begin
                    if (i_rows[ky][TIME_STEPS*(x+kx) + i_t]) begin
                        acc = acc + CH_SUM_W'($signed(i_kernel[ky][kx]));
                    end
                end
            end
            w_sums[x] = acc;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_valid) begin
            o_sums <= w_sums;
            o_t    <= i_t;
        end
    end

endmodule

// File: rtl/psum_accum.sv
// partial-sum row buffer with one slice per time step
// first pass overwrites, later passes accumulate
`timescale 1ns/1ps

module psum_accum
    import spike_conv_pkg::*;
(
    input  logic           s_clk,
    input  logic           s_rst,
    input  logic           i_valid,
    input  logic [T_W-1:0] i_t,
    input  tree_row_t      i_row,
    input  logic           i_first_pass,
    output psum_row_t      o_psum
);

    psum_row_t r_psum;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_psum <= '0;
        end else if (i_valid) begin
            for (int x = 0; x < OUT_W; x++) begin
                if (i_first_pass) begin
                    r_psum[i_t][x] <= PSUM_W'($signed(i_row[x]));
                end else begin
                    r_psum[i_t][x] <= $signed(r_psum[i_t][x])
                                    + PSUM_W'($signed(i_row[x]));
                end
            end
        end
    end

    assign o_psum = r_psum;

endmodule

// File: rtl/spike_conv_pkg.sv
// sizes, widths and packed row types of the spiking convolution engine
// controller state enum
package spike_conv_pkg;

    localparam int QUAN_BITS  = 8;
    localparam int KSIZE      = 3;
    localparam int PE_NUM     = 4;
    localparam int IMG_W      = 16;
    localparam int OUT_W      = IMG_W - KSIZE + 1;
    localparam int TIME_STEPS = 2;
    localparam int W_BEATS    = PE_NUM * KSIZE;
    localparam int ROW_BEATS  = PE_NUM * KSIZE;
    localparam int CH_SUM_W   = 12;
    localparam int TREE_W     = 14;
    localparam int PSUM_W     = 18;
    localparam int MEM_W      = 20;
    localparam int PASS_W     = 4;
    localparam int THRD_W     = 16;
    localparam int BEAT_W     = $clog2(W_BEATS);
    localparam int T_W        = $clog2(TIME_STEPS);
    // pe, tree and psum stages
    localparam int DRAIN_CYC  = 3;

    typedef logic [KSIZE-1:0][QUAN_BITS-1:0]             weight_row_t;
    typedef logic [IMG_W*TIME_STEPS-1:0]                 spike_row_t;
    typedef logic [OUT_W-1:0][CH_SUM_W-1:0]              ch_sum_row_t;
    typedef logic [OUT_W-1:0][TREE_W-1:0]                tree_row_t;
    typedef logic [TIME_STEPS-1:0][OUT_W-1:0][PSUM_W-1:0] psum_row_t;
    typedef logic [OUT_W*TIME_STEPS-1:0]                 out_spikes_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_W,
        S_LOAD_ROWS,
        S_CAL,
        S_DRAIN,
        S_FIRE,
        S_OUT
    } ctrl_state_e;

endpackage

// File: rtl/spike_conv_top.sv
// top level of the spiking convolution engine
// controller, load buffers, per-channel PEs, add tree, psum and fire stage
`timescale 1ns/1ps

module spike_conv_top
    import spike_conv_pkg::*;
(
    input  logic                     s_clk,
    input  logic                     s_rst,
    input  logic                     i_cfg_valid,
    input  logic [PASS_W-1:0]        i_cfg_passes,
    input  logic signed [THRD_W-1:0] i_cfg_thrd,
    input  logic                     i_weight_valid,
    input  weight_row_t              i_weight,
    output logic                     o_weight_ready,
    input  logic                     i_spikes_valid,
    input  spike_row_t               i_spikes,
    output logic                     o_spikes_ready,
    output logic                     o_out_valid,
    output out_spikes_t              o_out_spikes,
    input  logic                     i_out_ready
);

    logic                                    w_w_we;
    logic                                    w_row_we;
    logic [BEAT_W-1:0]                       w_beat_idx;
    logic                                    w_cal_valid;
    logic [T_W-1:0]                          w_cal_t;
    logic                                    w_first_pass;
    logic                                    w_fire_start;
    logic                                    w_out_taken;
    weight_row_t [PE_NUM-1:0][KSIZE-1:0]     w_kernels;
    spike_row_t [PE_NUM-1:0][KSIZE-1:0]      w_rows;
    logic [PE_NUM-1:0]                       w_pe_valid;
    logic [PE_NUM-1:0][T_W-1:0]              w_pe_t;
    ch_sum_row_t [PE_NUM-1:0]                w_pe_sums;
    logic                                    w_tree_valid;
    logic [T_W-1:0]                          w_tree_t;
    tree_row_t                               w_tree_row;
    psum_row_t                               w_psum;

    conv_ctrl u_conv_ctrl (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_cfg_valid    (i_cfg_valid),
        .i_cfg_passes   (i_cfg_passes),
        .i_weight_valid (i_weight_valid),
        .i_spikes_valid (i_spikes_valid),
        .i_out_taken    (w_out_taken),
        .o_weight_ready (o_weight_ready),
        .o_spikes_ready (o_spikes_ready),
        .o_w_we         (w_w_we),
        .o_row_we       (w_row_we),
        .o_beat_idx     (w_beat_idx),
        .o_cal_valid    (w_cal_valid),
        .o_cal_t        (w_cal_t),
        .o_first_pass   (w_first_pass),
        .o_fire_start   (w_fire_start)
    );

    weight_buf u_weight_buf (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .i_we      (w_w_we),
        .i_idx     (w_beat_idx),
        .i_weight  (i_weight),
        .o_kernels (w_kernels)
    );

    ifmap_row_buf u_ifmap_row_buf (
        .s_clk    (s_clk),
        .s_rst    (s_rst),
        .i_we     (w_row_we),
        .i_idx    (w_beat_idx),
        .i_spikes (i_spikes),
        .o_rows   (w_rows)
    );

    for (genvar g = 0; g < PE_NUM; g++) begin : g_pe
        pe_channel u_pe_channel (
            .s_clk    (s_clk),
            .s_rst    (s_rst),
            .i_valid  (w_cal_valid),
            .i_t      (w_cal_t),
            .i_kernel (w_kernels[g]),
            .i_rows   (w_rows[g]),
            .o_valid  (w_pe_valid[g]),
            .o_t      (w_pe_t[g]),
            .o_sums   (w_pe_sums[g])
        );
    end

    // all channels run in lockstep
    channel_add_tree u_channel_add_tree (
        .s_clk   (s_clk),
        .s_rst   (s_rst),
        .i_valid (&w_pe_valid),
        .i_t     (w_pe_t[0]),
        .i_sums  (w_pe_sums),
        .o_valid (w_tree_valid),
        .o_t     (w_tree_t),
        .o_row   (w_tree_row)
    );

    psum_accum u_psum_accum (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_valid      (w_tree_valid),
        .i_t          (w_tree_t),
        .i_row        (w_tree_row),
        .i_first_pass (w_first_pass),
        .o_psum       (w_psum)
    );

    lif_fire u_lif_fire (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_cfg_valid  (i_cfg_valid),
        .i_cfg_thrd   (i_cfg_thrd),
        .i_fire_start (w_fire_start),
        .i_psum       (w_psum),
        .i_out_ready  (i_out_ready),
        .o_out_valid  (o_out_valid),
        .o_out_spikes (o_out_spikes),
        .o_out_taken  (w_out_taken)
    );

endmodule

// File: rtl/weight_buf.sv
// kernel register file, one kernel row written per beat
`timescale 1ns/1ps

module weight_buf
    import spike_conv_pkg::*;
(
    input  logic                                s_clk,
    input  logic                                s_rst,
    input  logic                                i_we,
    input  logic [BEAT_W-1:0]                   i_idx,
    input  weight_row_t                         i_weight,
    output weight_row_t [PE_NUM-1:0][KSIZE-1:0] o_kernels
);

    // beat n lands at channel n/3, row n%3
    weight_row_t [W_BEATS-1:0] r_mem;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_mem <= '0;
        end else if (i_we) begin
            r_mem[i_idx] <= i_weight;
        end
    end

    assign o_kernels = r_mem;

endmodule

// File: verif/tb_spike_conv.sv
// testbench for spike_conv_top with random jobs, load gaps and output stalls
// reference model of the convolution, pass accumulation and integrate-and-fire
`timescale 1ns/1ps

module tb_spike_conv
    import spike_conv_pkg::*;
;

    localparam int CLK_HALF     = 10;
    localparam int RST_CYCLES   = 10;
    localparam int MAX_PASSES   = 3;
    localparam int LOAD_TIMEOUT = 200;
    localparam int WAIT_TIMEOUT = 50;

    logic                     s_clk;
    logic                     s_rst;
    logic                     i_cfg_valid;
    logic [PASS_W-1:0]        i_cfg_passes;
    logic signed [THRD_W-1:0] i_cfg_thrd;
    logic                     i_weight_valid;
    weight_row_t              i_weight;
    logic                     o_weight_ready;
    logic                     i_spikes_valid;
    spike_row_t               i_spikes;
    logic                     o_spikes_ready;
    logic                     o_out_valid;
    out_spikes_t              o_out_spikes;
    logic                     i_out_ready;

    integer      seed;
    int          err_count;
    int          timeout_count;
    int          w_beats = 0;
    int          s_beats = 0;
    int          total_passes;
    weight_row_t w_mem [MAX_PASSES][W_BEATS];
    spike_row_t  sp_mem [MAX_PASSES][ROW_BEATS];

    spike_conv_top i_spike_conv_top (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_cfg_valid    (i_cfg_valid),
        .i_cfg_passes   (i_cfg_passes),
        .i_cfg_thrd     (i_cfg_thrd),
        .i_weight_valid (i_weight_valid),
        .i_weight       (i_weight),
        .o_weight_ready (o_weight_ready),
        .i_spikes_valid (i_spikes_valid),
        .i_spikes       (i_spikes),
        .o_spikes_ready (o_spikes_ready),
        .o_out_valid    (o_out_valid),
        .o_out_spikes   (o_out_spikes),
        .i_out_ready    (i_out_ready)
    );

    initial begin
        s_clk = 1'b0;
        forever #(CLK_HALF) s_clk = ~s_clk;
    end

    // accepted beats per stream over the whole run
    always @(posedge s_clk) begin
        if (i_weight_valid && o_weight_ready) begin
            w_beats <= w_beats + 1;
        end
        if (i_spikes_valid && o_spikes_ready) begin
            s_beats <= s_beats + 1;
        end
    end

    task automatic expect_equal(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        assert (act === exp) else begin
            err_count++;
            $display("ERR %0t %s exp=%0h act=%0h", $time, name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout at %0t while waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic fill_pass(input int p);
        logic [31:0] rnd;
        for (int b = 0; b < W_BEATS; b++) begin
            rnd = $random(seed);
            w_mem[p][b] = rnd[KSIZE*QUAN_BITS-1:0];
            rnd = $random(seed);
            sp_mem[p][b] = rnd[IMG_W*TIME_STEPS-1:0];
        end
    endtask

    // convolution summed over channels and passes followed by the fire rule per pixel
    function automatic out_spikes_t expected_spikes(input int passes, input int thrd);
        int          psum [TIME_STEPS][OUT_W];
        int          mem;
        int          b;
        out_spikes_t res;
        for (int t = 0; t < TIME_STEPS; t++) begin
            for (int x = 0; x < OUT_W; x++) begin
                psum[t][x] = 0;
            end
        end
        for (int p = 0; p < passes; p++) begin
            for (int c = 0; c < PE_NUM; c++) begin
                for (int ky = 0; ky < KSIZE; ky++) begin
                    b = c * KSIZE + ky;
                    for (int kx = 0; kx < KSIZE; kx++) begin
                        for (int t = 0; t < TIME_STEPS; t++) begin
                            for (int x = 0; x < OUT_W; x++) begin
                                if (sp_mem[p][b][TIME_STEPS*(x+kx) + t]) begin
                                    psum[t][x] += $signed(w_mem[p][b][kx]);
                                end
                            end
                        end
                    end
                end
            end
        end
        for (int x = 0; x < OUT_W; x++) begin
            mem = 0;
            for (int t = 0; t < TIME_STEPS; t++) begin
                mem += psum[t][x];
                res[TIME_STEPS*x + t] = (mem >= thrd);
                if (mem >= thrd) begin
                    mem = 0;
                end
            end
        end
        return res;
    endfunction

    task automatic drive_beat(input int p, input int b, input bit is_weight, input bit v);
        if (is_weight) begin
            i_weight_valid <= v;
            i_weight       <= w_mem[p][b];
        end else begin
            i_spikes_valid <= v;
            i_spikes       <= sp_mem[p][b];
        end
    endtask

    // one pass of one stream with random valid gaps
    task automatic load_stream(input int p, input bit is_weight);
        int beat;
        int cycles;
        bit took;
        beat = 0;
        cycles = 0;
        while (beat < W_BEATS) begin
            drive_beat(p, beat, is_weight, ($random(seed) & 3) != 0);
            @(posedge s_clk);
            took = is_weight ? (i_weight_valid && o_weight_ready)
                             : (i_spikes_valid && o_spikes_ready);
            if (took) begin
                beat++;
            end
            cycles++;
            if (cycles > LOAD_TIMEOUT) begin
                report_timeout(is_weight ? "weight beats" : "spike beats");
            end
        end
        // valid stays up one more cycle so a 13th beat would be seen
        drive_beat(p, W_BEATS - 1, is_weight, 1'b1);
        @(posedge s_clk);
        if (is_weight) begin
            expect_equal("o_weight_ready", 0, o_weight_ready);
        end else begin
            expect_equal("o_spikes_ready", 0, o_spikes_ready);
        end
        drive_beat(p, W_BEATS - 1, is_weight, 1'b0);
    endtask

    task automatic take_output(input out_spikes_t exp);
        int          cycles;
        int          hold;
        out_spikes_t seen;
        cycles = 0;
        while (!o_out_valid) begin
            @(posedge s_clk);
            cycles++;
            if (cycles > WAIT_TIMEOUT) begin
                report_timeout("o_out_valid after the last pass");
            end
        end
        expect_equal("o_out_spikes", exp, o_out_spikes);
        seen = o_out_spikes;
        hold = {$random(seed)} % 6;
        for (int k = 0; k <= hold; k++) begin
            if (k == hold) begin
                i_out_ready <= 1'b1;
            end
            @(posedge s_clk);
            expect_equal("o_out_valid", 1, o_out_valid);
            expect_equal("o_out_spikes", seen, o_out_spikes);
            expect_equal("o_weight_ready", 0, o_weight_ready);
            expect_equal("o_spikes_ready", 0, o_spikes_ready);
        end
        i_out_ready <= 1'b0;
    endtask

    // runs from the edge that enters S_IDLE to the output handshake
    task automatic run_job(input int passes, input int thrd);
        out_spikes_t exp;
        i_cfg_valid  <= 1'b1;
        i_cfg_passes <= PASS_W'(passes);
        i_cfg_thrd   <= THRD_W'(thrd);
        @(posedge s_clk);
        i_cfg_valid <= 1'b0;
        expect_equal("o_weight_ready", 0, o_weight_ready);
        expect_equal("o_out_valid", 0, o_out_valid);
        for (int p = 0; p < passes; p++) begin
            fill_pass(p);
            load_stream(p, 1'b1);
            load_stream(p, 1'b0);
        end
        exp = expected_spikes(passes, thrd);
        take_output(exp);
        total_passes += passes;
        expect_equal("weight beats", W_BEATS * total_passes, w_beats);
        expect_equal("spike beats", ROW_BEATS * total_passes, s_beats);
    endtask

    initial begin
        int cycles;
        seed           = 32'hc05eca7c;
        err_count      = 0;
        timeout_count  = 0;
        total_passes   = 0;
        s_rst          = 1'b1;
        i_cfg_valid    = 1'b0;
        i_cfg_passes   = '0;
        i_cfg_thrd     = '0;
        i_weight_valid = 1'b0;
        i_weight       = '0;
        i_spikes_valid = 1'b0;
        i_spikes       = '0;
        i_out_ready    = 1'b0;
        // first edge applies the reset
        @(posedge s_clk);
        repeat (RST_CYCLES - 1) begin
            @(posedge s_clk);
            expect_equal("o_weight_ready", 0, o_weight_ready);
            expect_equal("o_spikes_ready", 0, o_spikes_ready);
            expect_equal("o_out_valid", 0, o_out_valid);
        end
        s_rst <= 1'b0;
        run_job(1, 100);
        run_job(3, 300);
        // low and high threshold
        run_job(1, 8);
        run_job(1, 500);
        cycles = 0;
        while (!o_weight_ready) begin
            @(posedge s_clk);
            cycles++;
            if (cycles > WAIT_TIMEOUT) begin
                report_timeout("o_weight_ready after the output handshake");
            end
        end
        finish_run();
    end

endmodule
